// File: bench/referenceModel.svh
`ifndef REFERENCE_MODEL_SVH
`define REFERENCE_MODEL_SVH

// An 8-bit sum with bit 7 set counts as negative and is clipped to zero.
function automatic int reluByte(input int sum);
	int wrapped;
	wrapped = sum & 255;
	return (wrapped >= 128) ? 0 : wrapped;
endfunction

// Products keep their low byte only, and the sum wraps modulo 256.
function automatic inferenceResult expectedResult(input featureVector features);
	int hidden [FeatureCount];
	int score [ClassCount];
	int acc;
	int best;
	inferenceResult expected;
	for (int n = 0; n < FeatureCount; n++)
	begin
		acc = int'(hiddenBias[n]);
		for (int i = 0; i < FeatureCount; i++)
		begin
			acc += (int'(features.element[i]) * int'(hiddenWeights[n][i])) & 255;
		end
		hidden[n] = reluByte(acc);
	end
	for (int c = 0; c < ClassCount; c++)
	begin
		acc = int'(outputBias[c]);
		for (int i = 0; i < FeatureCount; i++)
		begin
			acc += (hidden[i] * int'(outputWeights[c][i])) & 255; // Hidden values are 0 to 127.
		end
		score[c] = reluByte(acc);
	end
	best = 0;
	for (int c = 1; c < ClassCount; c++)
	begin
		if (score[c] > score[best])
		begin
			best = c; // Strictly greater, so a tie keeps the lower index.
		end
	end
	for (int c = 0; c < ClassCount; c++)
	begin
		expected.scores[c] = score[c][7:0];
	end
	expected.classIndex = best[$clog2(ClassCount)-1:0];
	return expected;
endfunction

`endif

// File: bench/inferenceBench.sv
`timescale 1ns/1ps

module inferenceBench
	import nnPkg::*;
;

	localparam int ClockPeriod = 4;
	localparam int RandomCount = 200;
	localparam int VectorCount = RandomCount + 5; // Zero vector and four extreme vectors.
	localparam int AckLatency = 8;

	logic clk;
	logic reset;
	featureVector features;
	logic req;
	logic ack;
	inferenceResult result;

	int unsigned lcgState = 83241;
	int cycleCount = 0;
	int reqCycle = 0;
	int resultCount = 0;
	string currentName = "idle";

	`include "referenceModel.svh"

	inferenceTop inferenceTop_inst (
		.clk(clk),
		.reset(reset),
		.features(features),
		.req(req),
		.ack(ack),
		.result(result)
	);

	initial
	begin
		clk = 1'b0;
		forever #(ClockPeriod / 2) clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
	end

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic featureVector randomVector();
		featureVector vector;
		logic [31:0] draw;
		for (int i = 0; i < FeatureCount; i++)
		begin
			draw = nextRandom();
			vector.element[i] = draw[23:16]; // Upper bits of an LCG are the better mixed ones.
		end
		return vector;
	endfunction

	function automatic featureVector alternatingVector(input signedByte even, input signedByte odd);
		featureVector vector;
		for (int i = 0; i < FeatureCount; i++)
		begin
			vector.element[i] = (i % 2 == 0) ? even : odd;
		end
		return vector;
	endfunction

	task automatic reportFailure(input string reason);
		$display("%s", reason);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic compareValue(input string testName, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected)
		begin
			reportFailure($sformatf("CHECK FAILED %s expected %0h actual %0h",
				testName, expected, actual));
		end
	endtask

	// One full four-phase transaction with a random hold of req after ack.
	task automatic applyVector(input string testName, input featureVector vector);
		int holdCycles;
		inferenceResult heldResult;
		@(posedge clk);
		#1;
		features = vector;
		currentName = testName;
		reqCycle = cycleCount;
		req = 1'b1;
		do
		begin
			@(negedge clk);
		end
		while (!ack);
		heldResult = result;
		holdCycles = (nextRandom() >> 16) % 7;
		repeat (holdCycles)
		begin
			@(negedge clk);
			compareValue({testName, " ack held"}, 1, ack);
			compareValue({testName, " result held"}, heldResult, result);
		end
		@(posedge clk);
		#1;
		req = 1'b0;
		@(negedge clk);
		compareValue({testName, " ack before release edge"}, 1, ack);
		@(negedge clk);
		compareValue({testName, " ack released"}, 0, ack);
		compareValue({testName, " result after release"}, heldResult, result);
	endtask

	// Checks every result as ack rises.
	initial
	begin : compareResults
		inferenceResult expected;
		logic ackBefore;
		ackBefore = 1'b0;
		forever
		begin
			@(negedge clk);
			if (ack === 1'b1 && ackBefore === 1'b0)
			begin
				expected = expectedResult(features);
				compareValue({currentName, " scores"}, expected.scores, result.scores);
				compareValue({currentName, " classIndex"}, expected.classIndex,
					result.classIndex);
				compareValue({currentName, " latency"}, AckLatency,
					cycleCount - reqCycle - 1);
				resultCount++;
			end
			ackBefore = ack;
		end
	end

	initial
	begin : watchdog
		#(2 * VectorCount * 20 * ClockPeriod);
		reportFailure("Watchdog expired, the run timed out before all vectors were done.");
	end

	initial
	begin : mainSequence
		reset = 1'b1;
		req = 1'b0;
		features = '0;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		@(negedge clk);
		compareValue("reset ack", 0, ack);
		compareValue("reset result", 0, result);

		applyVector("zero vector", alternatingVector(8'sd0, 8'sd0));
		applyVector("all max", alternatingVector(8'sd127, 8'sd127));
		applyVector("all min", alternatingVector(-8'sd128, -8'sd128));
		applyVector("alternating max min", alternatingVector(8'sd127, -8'sd128));
		applyVector("alternating min max", alternatingVector(-8'sd128, 8'sd127));
		for (int i = 0; i < RandomCount; i++)
		begin
			applyVector($sformatf("random %0d", i), randomVector());
		end

		repeat (2) @(posedge clk);
		if (resultCount == VectorCount)
		begin
			$display("Everything OK");
			$finish;
		end
		else
		begin
			reportFailure($sformatf("Only %0d of %0d results reached the compare process.",
				resultCount, VectorCount));
		end
	end

endmodule

// File: logic/argmaxUnit.sv
`timescale 1ns/1ps

module argmaxUnit
	import nnPkg::*;
#(
	parameter int ClassCount = 4
)
(
	input logic clk,
	input logic reset,
	input logic [0:ClassCount-1][7:0] scores,
	input logic loadResult,
	output inferenceResult result
);

	localparam int IndexWidth = (ClassCount > 1) ? $clog2(ClassCount) : 1;
	localparam int Leaves = 1 << IndexWidth;

	// Heap-ordered tree, node 1 is the root and the leaves start at index Leaves.
	logic [7:0] nodeScore [1:2*Leaves-1];
	logic [IndexWidth-1:0] nodeIndex [1:2*Leaves-1];

	always_comb
	begin
		for (int leaf = 0; leaf < Leaves; leaf++)
		begin
			nodeScore[Leaves + leaf] = 8'd0; // Padding leaves never beat a real score.
			nodeIndex[Leaves + leaf] = IndexWidth'(leaf);
			if (leaf < ClassCount)
			begin
				nodeScore[Leaves + leaf] = scores[leaf];
			end
		end
		// The left child holds the lower indices and keeps a tie.
		for (int node = Leaves - 1; node > 0; node--)
		begin
			if (nodeScore[2 * node + 1] > nodeScore[2 * node])
			begin
				nodeScore[node] = nodeScore[2 * node + 1];
				nodeIndex[node] = nodeIndex[2 * node + 1];
			end
			else
			begin
				nodeScore[node] = nodeScore[2 * node];
				nodeIndex[node] = nodeIndex[2 * node];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			result <= '0;
		end
		else if (loadResult)
		begin
			result.scores <= scores;
			result.classIndex <= nodeIndex[1];
		end
	end

	classIndexInRange: assert property (@(posedge clk) disable iff (reset)
		loadResult |=> result.classIndex < ClassCount);

endmodule

// File: logic/denseLayer.sv
`timescale 1ns/1ps

module denseLayer
	import nnPkg::*;
#(
	parameter int InputCount = FeatureCount,
	parameter int NodeCount = FeatureCount,
	parameter signedByte [0:NodeCount-1][0:InputCount-1] Weights = '0,
	parameter signedByte [0:NodeCount-1] Bias = '0
)
(
	input logic clk,
	input logic reset,
	input signedByte [0:InputCount-1] inputs,
	output logic [0:NodeCount-1][7:0] activations
);

	// Each neuron sees the full input vector and takes its own row of the table.
	for (genvar n = 0; n < NodeCount; n++)
	begin : node
		neuronNode #(
			.InputCount(InputCount),
			.Weights(Weights[n]),
			.Bias(Bias[n])
		) neuron (
			.clk(clk),
			.reset(reset),
			.inputs(inputs),
			.activation(activations[n])
		);
	end

endmodule

// File: logic/inferenceTop.sv
`timescale 1ns/1ps

module inferenceTop
	import nnPkg::*;
(
	input logic clk,
	input logic reset,
	input featureVector features,
	input logic req,
	output logic ack,
	output inferenceResult result
);

	hiddenVector hidden;
	logic [0:ClassCount-1][7:0] scores; // Raw output-layer activations.
	logic loadResult;

	// Two layers of three stages each.
	layerSequencer #(
		.PipelineDepth(6)
	) sequencer (
		.clk(clk),
		.reset(reset),
		.req(req),
		.ack(ack),
		.loadResult(loadResult)
	);

	denseLayer #(
		.InputCount(FeatureCount),
		.NodeCount(FeatureCount),
		.Weights(hiddenWeights),
		.Bias(hiddenBias)
	) hiddenLayer (
		.clk(clk),
		.reset(reset),
		.inputs(features.element),
		.activations(hidden.element)
	);

	denseLayer #(
		.InputCount(FeatureCount),
		.NodeCount(ClassCount),
		.Weights(outputWeights),
		.Bias(outputBias)
	) outputLayer (
		.clk(clk),
		.reset(reset),
		.inputs(hidden.element),
		.activations(scores)
	);

	argmaxUnit #(
		.ClassCount(ClassCount)
	) argmax (
		.clk(clk),
		.reset(reset),
		.scores(scores),
		.loadResult(loadResult),
		.result(result)
	);

endmodule

// File: logic/layerSequencer.sv
`timescale 1ns/1ps

module layerSequencer
#(
	parameter int PipelineDepth = 6
)
(
	input logic clk,
	input logic reset,
	input logic req,
	output logic ack,
	output logic loadResult
);

	localparam int CountWidth = $clog2(PipelineDepth + 1);

	typedef enum logic [1:0] {idle, counting, acknowledge} seqState;

	seqState state;
	logic [CountWidth-1:0] count;

	// loadResult rises PipelineDepth + 1 edges after req is taken and ack one edge later.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= idle;
			count <= '0;
			ack <= 1'b0;
			loadResult <= 1'b0;
		end
		else
		begin
			loadResult <= 1'b0;
			case (state)
				idle:
					if (req)
					begin
						state <= counting;
						count <= CountWidth'(PipelineDepth);
					end
				counting:
					if (count != '0)
					begin
						count <= count - 1'b1;
					end
					else
					begin
						loadResult <= 1'b1; // Result is captured on the next edge.
						state <= acknowledge;
					end
				acknowledge:
					// Held here for as long as the host keeps req high.
					if (req)
					begin
						ack <= 1'b1;
					end
					else
					begin
						ack <= 1'b0;
						state <= idle;
					end
				default:
					state <= idle;
			endcase
		end
	end

	// The host must still be requesting when ack goes high.
	ackNeedsReq: assert property (@(posedge clk) disable iff (reset)
		!ack && !req |=> !ack);

	noLoadInIdle: assert property (@(posedge clk) disable iff (reset)
		state == idle |-> !loadResult);

endmodule

// File: logic/neuronNode.sv
`timescale 1ns/1ps

module neuronNode
	import nnPkg::*;
#(
	parameter int InputCount = FeatureCount,
	parameter signedByte [0:InputCount-1] Weights = '0,
	parameter signedByte Bias = '0
)
(
	input logic clk,
	input logic reset,
	input signedByte [0:InputCount-1] inputs,
	output logic [7:0] activation
);

	signedByte [0:InputCount-1] inputReg;
	signedByte [0:InputCount-1] products;
	signedByte rawSum;
	signedByte sumReg;

	// Only the low byte of each product is kept.
	always_comb
	begin
		for (int i = 0; i < InputCount; i++)
		begin
			products[i] = inputReg[i] * Weights[i];
		end
	end

	always_comb
	begin
		rawSum = Bias;
		for (int i = 0; i < InputCount; i++)
		begin
			rawSum = rawSum + products[i]; // Wraps modulo 256.
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inputReg <= '0;
			sumReg <= '0;
			activation <= '0;
		end
		else
		begin
			inputReg <= inputs;
			sumReg <= rawSum;
			// ReLU on the registered sum.
			if (sumReg[7])
			begin
				activation <= 8'd0;
			end
			else
			begin
				activation <= sumReg;
			end
		end
	end

endmodule

// File: logic/nnPkg.sv
package nnPkg;

	localparam int FeatureCount = 15;
	localparam int ClassCount = 4;

	typedef logic signed [7:0] signedByte;

	// Element 0 sits in the most significant byte.
	typedef struct packed
	{
		signedByte [0:FeatureCount-1] element;
	} featureVector;

	typedef struct packed
	{
		signedByte [0:FeatureCount-1] element;
	} hiddenVector;

	typedef struct packed
	{
		logic [0:ClassCount-1][7:0] scores;
		logic [$clog2(ClassCount)-1:0] classIndex;
	} inferenceResult;

	// Row n holds the weights of hidden neuron n.
	localparam signedByte [0:FeatureCount-1][0:FeatureCount-1] hiddenWeights = '{
		'{  12,  -34,   56,   -7,   21,   90,  -45,    3, -118,   64,   17,  -29,    8,   77,  -61},
		'{ -83,    5,   40,  111,  -16,   -2,   33,  -97,   58,   26,  -71,    9,  102,  -38,   14},
		'{  47,   66, -120,   19,  -55,   81,    7,  -13,   29,  -88,   35,  124,   -4,  -50,   72},
		'{  -9,  101,   23,  -67,   88,  -31,   54,   16,   -3,   42, -110,   61,  -25,    6,   95},
		'{  70,  -18,  -44,   85,    2,   37,  -92,  121,   11,  -57,   68,   -6,   49, -100,   20},
		'{-116,   28,   63,  -39,   74,  -11,   15,  -82,   99,    4,   31,  -53,   87,   22,   -1},
		'{  36,  -74,    1,   52, -107,  118,  -20,   43,  -66,   13,   -8,   95,  -33,   59,   27},
		'{   5,   89,  -59,  -24,   41,   60,  113,  -15,   24,  -79,   50,   18, -102,   30,  -43},
		'{ -64,   10,   79,  108,  -28,  -95,   38,   57,  -12,   84,  -47,   25,    3, -119,   62},
		'{  93,  -52,   14,  -86,   67,   20,  -37,    8,  105,  -21,   76,  -63,   44,   11,  -90},
		'{ -27,   48,  -99,   32,   13,  -70,   86,  -41,   55,  117,   -5,   39,  -78,   69,   18},
		'{  58,   -3,   34,   71, -123,   46,  -58,   97,  -19,    7,   26,  -84,   62,  -14,  103},
		'{ -40,  115,  -26,    9,   80,  -62,    4, -109,   73,   45,  -92,   12,   28,   96,  -35},
		'{ -87,  -94,    8,  -58,   32,  -21,    9, -100,   -5,   65,   51,  -69,  -42, -105,  -50},
		'{  19,  -46,   92,   65,  -33,   15,  -75,   27,   82, -125,   10,   53,  -17,   40,    0}
	};

	localparam signedByte [0:FeatureCount-1] hiddenBias = '{
		4, -12, 20, -3, 9, 15, -7, 1, 11, -20, 6, 25, -2, -5, 13
	};

	localparam signedByte [0:ClassCount-1][0:FeatureCount-1] outputWeights = '{
		'{  22,  -41,   17,   63,   -9,   35,  -58,   12,   48,  -27,    5,   71,  -36,   19,   44},
		'{ -31,   57,   26,  -14,   80,  -47,    9,   68,  -22,   39,  -73,    3,   51,   -8,   15},
		'{  45,    6,  -62,   29,   18,   77,  -11,  -53,   34,   60,   24,  -40,    7,   88,  -19},
		'{ -15,   33,   49,  -70,   37,    2,   66,   21,  -44,   13,   59,   28,  -90,   42,   10}
	};

	localparam signedByte [0:ClassCount-1] outputBias = '{7, -4, 12, 3};

endpackage

// File: project.f
+incdir+bench
logic/nnPkg.sv
logic/neuronNode.sv
logic/denseLayer.sv
logic/argmaxUnit.sv
logic/layerSequencer.sv
logic/inferenceTop.sv
bench/inferenceBench.sv
